/* Makefile */
SRCS := $(wildcard hdl/*.sv test/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vcore_tb: compile.f $(SRCS)
	verilator --binary --assert --timescale 1ns/1ps --top-module core_tb -f compile.f

run: obj_dir/Vcore_tb
	./obj_dir/Vcore_tb > sim.log 2>&1; cat sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* compile.f */
hdl/rv_isa_pkg.sv
hdl/core_bus_pkg.sv
hdl/alu.sv
hdl/branch_unit.sv
hdl/reg_file.sv
hdl/instr_decoder.sv
hdl/core_ctrl.sv
hdl/core_top.sv
test/core_props.sv
test/core_tb.sv

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu
	import rv_isa_pkg::*;
(
	input  alu_op_t op,
	input  xlen_t   a,
	input  xlen_t   b,
	output xlen_t   result
);

	shamt_t shamt;

	assign shamt = b[SHAMT_W-1:0]; // low bits only

	always_comb begin
		case (op)
			ALU_ADD:    result = a + b;
			ALU_SUB:    result = a - b;
			ALU_XOR:    result = a ^ b;
			ALU_OR:     result = a | b;
			ALU_AND:    result = a & b;
			ALU_SLL:    result = a << shamt;
			ALU_SRL:    result = a >> shamt;
			ALU_SRA:    result = xlen_t'($signed(a) >>> shamt);
			ALU_SLT:    result = xlen_t'($signed(a) < $signed(b));
			ALU_SLTU:   result = xlen_t'(a < b);
			ALU_PASS_B: result = b; // lui
			default:    result = '0;
		endcase
	end

endmodule

/* hdl/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit
	import rv_isa_pkg::*;
(
	input  addr_t               pc,
	input  xlen_t               imm,
	input  xlen_t               rs1_data,
	input  xlen_t               rs2_data,
	input  logic [FUNCT3_W-1:0] funct3,
	input  logic                is_branch,
	input  logic                is_jal,
	output addr_t               next_pc
);

	logic taken;

	always_comb begin
		case (funct3)
			F3_BEQ:  taken = (rs1_data == rs2_data);
			F3_BNE:  taken = (rs1_data != rs2_data);
			F3_BLT:  taken = ($signed(rs1_data) < $signed(rs2_data));
			F3_BGE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
			F3_BLTU: taken = (rs1_data < rs2_data);
			F3_BGEU: taken = (rs1_data >= rs2_data);
			default: taken = 1'b0;
		endcase
	end

	assign next_pc = ((is_branch && taken) || is_jal) ? pc + imm : pc + INSTR_BYTES;

endmodule

/* hdl/core_bus_pkg.sv */
package core_bus_pkg;

	import rv_isa_pkg::*;

	// axi4-lite read address
	typedef struct packed {
		addr_t      araddr;
		logic [2:0] arprot;
	} axi_ar_t;

	// axi4-lite read data
	typedef struct packed {
		xlen_t      rdata;
		logic [1:0] rresp;
	} axi_r_t;

	typedef struct packed {
		reg_idx_t            rd;
		reg_idx_t            rs1;
		reg_idx_t            rs2;
		xlen_t               imm;
		alu_op_t             alu_op;
		logic                use_imm; // b operand from imm
		logic                is_branch;
		logic                is_jal;
		logic                writes_rd;
		logic                src_pc; // a operand from pc for auipc
		logic [FUNCT3_W-1:0] funct3;
	} decoded_t;

	typedef struct packed {
		addr_t    pc;
		reg_idx_t rd;
		xlen_t    wdata;
		logic     wen;
	} retire_t;

endpackage

/* hdl/core_ctrl.sv */
`timescale 1ns/1ps

module core_ctrl
	import rv_isa_pkg::*;
	import core_bus_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	output logic     ar_valid,
	input  logic     ar_ready,
	output axi_ar_t  ar,
	input  logic     r_valid,
	output logic     r_ready,
	input  axi_r_t   r,
	output logic     retire_valid,
	output retire_t  retire,
	output instr_t   instr,
	output logic     instr_load,
	input  decoded_t dec,
	output logic     rf_wen,
	output xlen_t    rf_wdata,
	input  xlen_t    alu_result,
	output addr_t    pc,
	input  addr_t    next_pc
);

	ctrl_state_t state;
	xlen_t       wb_data;
	addr_t       pc_next_q;
	logic        wb_wen;

	assign ar       = '{araddr: pc, arprot: 3'b000}; // pc only moves in writeback
	assign wb_wen   = dec.writes_rd && (dec.rd != '0);
	assign rf_wen   = (state == ST_WRITEBACK) && wb_wen;
	assign rf_wdata = wb_data;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state        <= ST_FETCH;
			pc           <= '0;
			ar_valid     <= 1'b0;
			r_ready      <= 1'b0;
			instr_load   <= 1'b0;
			retire_valid <= 1'b0;
		end else begin
			instr_load   <= 1'b0;
			retire_valid <= 1'b0;
			case (state)
				ST_FETCH: begin
					if (!ar_valid) begin
						ar_valid <= 1'b1;
					end else if (ar_ready) begin
						ar_valid <= 1'b0;
						r_ready  <= 1'b1;
						state    <= ST_WAIT;
					end
				end
				ST_WAIT: begin
					if (r_valid && r_ready) begin
						r_ready    <= 1'b0;
						instr_load <= 1'b1; // decoder samples during decode
						state      <= ST_DECODE;
					end
				end
				ST_DECODE: state <= ST_EXECUTE;
				ST_EXECUTE: state <= ST_WRITEBACK;
				ST_WRITEBACK: begin
					pc           <= pc_next_q;
					retire_valid <= 1'b1;
					state        <= ST_FETCH;
				end
				default: state <= ST_FETCH;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_WAIT && r_valid && r_ready)
			instr <= r.rdata; // rresp ignored
		if (state == ST_EXECUTE) begin
			wb_data   <= dec.is_jal ? pc + INSTR_BYTES : alu_result; // link addr for jal
			pc_next_q <= next_pc;
		end
		if (state == ST_WRITEBACK)
			retire <= '{pc: pc, rd: dec.rd, wdata: wb_data, wen: wb_wen};
	end

endmodule

/* hdl/core_top.sv */
`timescale 1ns/1ps

module core_top
	import rv_isa_pkg::*;
	import core_bus_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	output logic    ar_valid,
	input  logic    ar_ready,
	output axi_ar_t ar,
	input  logic    r_valid,
	output logic    r_ready,
	input  axi_r_t  r,
	output logic    retire_valid,
	output retire_t retire
);

	instr_t   instr;
	logic     instr_load;
	decoded_t dec;
	logic     rf_wen;
	xlen_t    rf_wdata;
	xlen_t    rs1_data;
	xlen_t    rs2_data;
	xlen_t    alu_a;
	xlen_t    alu_b;
	xlen_t    alu_result;
	addr_t    pc;
	addr_t    next_pc;

	// operand select from decoder flags
	assign alu_a = dec.src_pc ? pc : rs1_data;
	assign alu_b = dec.use_imm ? dec.imm : rs2_data;

	core_ctrl i_core_ctrl (
		.clk(clk), .rst(rst),
		.ar_valid(ar_valid), .ar_ready(ar_ready), .ar(ar),
		.r_valid(r_valid), .r_ready(r_ready), .r(r),
		.retire_valid(retire_valid), .retire(retire),
		.instr(instr), .instr_load(instr_load), .dec(dec),
		.rf_wen(rf_wen), .rf_wdata(rf_wdata),
		.alu_result(alu_result),
		.pc(pc), .next_pc(next_pc)
	);

	instr_decoder i_instr_decoder (
		.clk(clk), .rst(rst),
		.instr(instr), .instr_load(instr_load), .dec(dec)
	);

	reg_file i_reg_file (
		.clk(clk), .rst(rst),
		.rs1(dec.rs1), .rs2(dec.rs2), .rd(dec.rd),
		.wen(rf_wen), .wdata(rf_wdata),
		.rs1_data(rs1_data), .rs2_data(rs2_data)
	);

	alu i_alu (
		.op(dec.alu_op), .a(alu_a), .b(alu_b), .result(alu_result)
	);

	branch_unit i_branch_unit (
		.pc(pc), .imm(dec.imm),
		.rs1_data(rs1_data), .rs2_data(rs2_data),
		.funct3(dec.funct3), .is_branch(dec.is_branch), .is_jal(dec.is_jal),
		.next_pc(next_pc)
	);

endmodule

/* hdl/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder
	import rv_isa_pkg::*;
	import core_bus_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  instr_t   instr,
	input  logic     instr_load,
	output decoded_t dec
);

	logic [OPCODE_W-1:0] opcode;
	logic [FUNCT3_W-1:0] funct3;
	logic [FUNCT7_W-1:0] funct7;
	logic                alt;
	logic                op_legal;
	alu_op_t             base_op;
	decoded_t            nxt;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign alt    = (funct7 == F7_ALT);

	// shared by register and immediate forms
	always_comb begin
		case (funct3)
			F3_ADD_SUB: base_op = (alt && opcode == OP_REG) ? ALU_SUB : ALU_ADD;
			F3_SLL:     base_op = ALU_SLL;
			F3_SLT:     base_op = ALU_SLT;
			F3_SLTU:    base_op = ALU_SLTU;
			F3_XOR:     base_op = ALU_XOR;
			F3_SR:      base_op = alt ? ALU_SRA : ALU_SRL;
			F3_OR:      base_op = ALU_OR;
			F3_AND:     base_op = ALU_AND;
			default:    base_op = ALU_ADD;
		endcase
	end

	always_comb begin
		case (funct3)
			F3_ADD_SUB: op_legal = (funct7 == F7_BASE) || (alt && opcode == OP_REG);
			F3_SR:      op_legal = (funct7 == F7_BASE) || alt;
			default:    op_legal = (funct7 == F7_BASE);
		endcase
		if (opcode == OP_IMM && funct3 != F3_SLL && funct3 != F3_SR)
			op_legal = 1'b1; // upper bits are immediate here
	end

	always_comb begin
		nxt        = '0; // unknown encodings stay a no-op
		nxt.rd     = instr[11:7];
		nxt.rs1    = instr[19:15];
		nxt.rs2    = instr[24:20];
		nxt.funct3 = funct3;
		nxt.alu_op = base_op;
		case (opcode)
			OP_REG: nxt.writes_rd = op_legal;
			OP_IMM: begin
				nxt.imm       = {{20{instr[31]}}, instr[31:20]};
				nxt.use_imm   = 1'b1;
				nxt.writes_rd = op_legal;
			end
			OP_BRANCH: begin
				nxt.imm       = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
				nxt.is_branch = funct3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
			end
			OP_JAL: begin
				nxt.imm       = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
				nxt.is_jal    = 1'b1;
				nxt.writes_rd = 1'b1;
			end
			OP_LUI: begin
				nxt.imm       = {instr[31:12], 12'b0};
				nxt.alu_op    = ALU_PASS_B;
				nxt.use_imm   = 1'b1;
				nxt.writes_rd = 1'b1;
			end
			OP_AUIPC: begin
				nxt.imm       = {instr[31:12], 12'b0};
				nxt.alu_op    = ALU_ADD;
				nxt.src_pc    = 1'b1;
				nxt.use_imm   = 1'b1;
				nxt.writes_rd = 1'b1;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			dec <= '0;
		else if (instr_load)
			dec <= nxt;
	end

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/1ps

module reg_file
	import rv_isa_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  reg_idx_t rs1,
	input  reg_idx_t rs2,
	input  reg_idx_t rd,
	input  logic     wen,
	input  xlen_t    wdata,
	output xlen_t    rs1_data,
	output xlen_t    rs2_data
);

	xlen_t regs [NUM_REGS];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wen && rd != '0) begin
			regs[rd] <= wdata;
		end
	end

	// x0 hardwired to zero
	assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* hdl/rv_isa_pkg.sv */
package rv_isa_pkg;

	localparam int XLEN      = 32;
	localparam int REG_IDX_W = 5;
	localparam int SHAMT_W   = 5;
	localparam int OPCODE_W  = 7;
	localparam int FUNCT3_W  = 3;
	localparam int FUNCT7_W  = 7;

	typedef logic [XLEN-1:0]      xlen_t;
	typedef logic [XLEN-1:0]      addr_t;
	typedef logic [31:0]          instr_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;
	typedef logic [SHAMT_W-1:0]   shamt_t;

	localparam int    NUM_REGS    = 32;
	localparam addr_t INSTR_BYTES = 32'd4;

	localparam logic [OPCODE_W-1:0] OP_REG    = 7'b0110011;
	localparam logic [OPCODE_W-1:0] OP_IMM    = 7'b0010011;
	localparam logic [OPCODE_W-1:0] OP_BRANCH = 7'b1100011;
	localparam logic [OPCODE_W-1:0] OP_JAL    = 7'b1101111;
	localparam logic [OPCODE_W-1:0] OP_LUI    = 7'b0110111;
	localparam logic [OPCODE_W-1:0] OP_AUIPC  = 7'b0010111;

	// alu funct3
	localparam logic [FUNCT3_W-1:0] F3_ADD_SUB = 3'b000;
	localparam logic [FUNCT3_W-1:0] F3_SLL     = 3'b001;
	localparam logic [FUNCT3_W-1:0] F3_SLT     = 3'b010;
	localparam logic [FUNCT3_W-1:0] F3_SLTU    = 3'b011;
	localparam logic [FUNCT3_W-1:0] F3_XOR     = 3'b100;
	localparam logic [FUNCT3_W-1:0] F3_SR      = 3'b101;
	localparam logic [FUNCT3_W-1:0] F3_OR      = 3'b110;
	localparam logic [FUNCT3_W-1:0] F3_AND     = 3'b111;

	// branch funct3
	localparam logic [FUNCT3_W-1:0] F3_BEQ  = 3'b000;
	localparam logic [FUNCT3_W-1:0] F3_BNE  = 3'b001;
	localparam logic [FUNCT3_W-1:0] F3_BLT  = 3'b100;
	localparam logic [FUNCT3_W-1:0] F3_BGE  = 3'b101;
	localparam logic [FUNCT3_W-1:0] F3_BLTU = 3'b110;
	localparam logic [FUNCT3_W-1:0] F3_BGEU = 3'b111;

	localparam logic [FUNCT7_W-1:0] F7_BASE = 7'b0000000;
	localparam logic [FUNCT7_W-1:0] F7_ALT  = 7'b0100000; // sub, sra, srai

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND, ALU_SLL,
		ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_PASS_B
	} alu_op_t;

	typedef enum logic [2:0] {
		ST_FETCH, ST_WAIT, ST_DECODE, ST_EXECUTE, ST_WRITEBACK
	} ctrl_state_t;

endpackage

/* test/core_props.sv */
`timescale 1ns/1ps

module core_props
	import core_bus_pkg::*;
(
	input logic    clk,
	input logic    rst,
	input logic    ar_valid,
	input logic    ar_ready,
	input axi_ar_t ar,
	input logic    r_ready,
	input logic    retire_valid
);

	int fail_count = 0; // polled by the testbench

	// address and valid held until accepted
	ar_hold: assert property (@(posedge clk) disable iff (rst)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar))
		else begin
			fail_count++;
			$error("read address changed or dropped before it was accepted");
		end

	r_after_ar: assert property (@(posedge clk) disable iff (rst)
		$rose(r_ready) |-> $past(ar_valid && ar_ready))
		else begin
			fail_count++;
			$error("r_ready raised without an accepted read address");
		end

	retire_pulse: assert property (@(posedge clk) disable iff (rst)
		retire_valid |=> !retire_valid)
		else begin
			fail_count++;
			$error("retire_valid held for two cycles");
		end

endmodule

bind core_ctrl core_props i_core_props (
	.clk(clk), .rst(rst), .ar_valid(ar_valid), .ar_ready(ar_ready), .ar(ar),
	.r_ready(r_ready), .retire_valid(retire_valid)
);

/* test/core_tb.sv */
`timescale 1ns/1ps

module core_tb
	import rv_isa_pkg::*;
	import core_bus_pkg::*;
();

	localparam int RESET_CYCLES = 10;
	localparam int PROG_WORDS   = 256;
	localparam int NUM_RETIRES  = 3000;
	localparam int TIMEOUT      = NUM_RETIRES * 12;

	logic        clk      = 1'b0;
	logic        rst      = 1'b1;
	logic        ar_ready = 1'b0;
	logic        r_valid  = 1'b0;
	axi_r_t      r        = '0;
	logic        ar_valid;
	logic        r_ready;
	axi_ar_t     ar;
	logic        retire_valid;
	retire_t     retire;

	logic [31:0] lfsr = 32'he953ff6f;
	instr_t      prog [PROG_WORDS];
	xlen_t       model_regs [NUM_REGS];
	addr_t       model_pc = '0;
	logic [1:0]  ar_cnt = 2'd0;
	logic [1:0]  r_cnt = 2'd0;
	logic        r_pend = 1'b0;
	addr_t       rd_addr = '0;
	int          cycles = 0;
	int          retired = 0;
	logic        r_seen = 1'b0;

	core_top i_core_top (
		.clk(clk), .rst(rst),
		.ar_valid(ar_valid), .ar_ready(ar_ready), .ar(ar),
		.r_valid(r_valid), .r_ready(r_ready), .r(r),
		.retire_valid(retire_valid), .retire(retire)
	);

	always #10 clk = ~clk;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] rand_bits(input int n);
		logic        fb;
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v    = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic instr_t gen_instr();
		logic [3:0]  kind;
		reg_idx_t    rd;
		reg_idx_t    rs1;
		reg_idx_t    rs2;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [11:0] imm;
		logic [3:0]  n;
		logic [12:0] boff;
		logic [20:0] joff;
		kind = 4'(rand_bits(4));
		rd   = reg_idx_t'(rand_bits(3)); // x0..x7 for more dependencies
		rs1  = reg_idx_t'(rand_bits(3));
		rs2  = reg_idx_t'(rand_bits(3));
		f3   = 3'(rand_bits(3));
		f7   = ((f3 == F3_ADD_SUB || f3 == F3_SR) && rand_bits(1) != 0) ? F7_ALT : F7_BASE;
		imm  = 12'(rand_bits(12));
		if (f3 == F3_SLL || f3 == F3_SR)
			imm = {f7, imm[4:0]};
		n = 4'(rand_bits(4));
		if (n < 4'd2)
			n = n + 4'd2; // forward 8..60 bytes
		boff = {7'b0, n, 2'b00};
		joff = {15'b0, n, 2'b00};
		case (kind)
			4'd0, 4'd1, 4'd2: return {f7, rs2, rs1, f3, rd, OP_REG};
			4'd3, 4'd4, 4'd5: return {imm, rs1, f3, rd, OP_IMM};
			4'd6: return {20'(rand_bits(20)), rd, OP_LUI};
			4'd7: return {20'(rand_bits(20)), rd, OP_AUIPC};
			4'd8, 4'd9, 4'd10, 4'd11:
				return {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], OP_BRANCH};
			4'd12: return {joff[20], joff[10:1], joff[11], joff[19:12], rd, OP_JAL};
			4'd13: return {7'(rand_bits(7)), rs2, rs1, f3, rd, OP_REG}; // mostly bad funct7
			4'd14: return {25'(rand_bits(25)), 7'b0000011}; // load opcode is unsupported
			default: return {1'b1, 11'(rand_bits(11)), rs1, F3_SLTU, rd, OP_IMM};
		endcase
	endfunction

	function automatic xlen_t alu_ref(input logic [2:0] f3, input logic alt,
			input xlen_t a, input xlen_t b);
		case (f3)
			F3_ADD_SUB: return alt ? a - b : a + b;
			F3_SLL:     return a << b[4:0];
			F3_SLT:     return {31'b0, $signed(a) < $signed(b)};
			F3_SLTU:    return {31'b0, a < b};
			F3_XOR:     return a ^ b;
			F3_SR: begin
				if (alt)
					return xlen_t'($signed(a) >>> b[4:0]);
				return a >> b[4:0];
			end
			F3_OR:      return a | b;
			default:    return a & b;
		endcase
	endfunction

	// executes the instruction at model_pc and updates the model state
	function automatic retire_t ref_step();
		instr_t     ins;
		logic [2:0] f3;
		logic [6:0] f7;
		xlen_t      a;
		xlen_t      b;
		xlen_t      imm_i;
		xlen_t      imm_b;
		xlen_t      imm_j;
		xlen_t      imm_u;
		xlen_t      res;
		logic       wr;
		logic       taken;
		addr_t      npc;
		retire_t    ret;
		ins   = prog[model_pc[9:2]];
		f3    = ins[14:12];
		f7    = ins[31:25];
		a     = model_regs[ins[19:15]];
		b     = model_regs[ins[24:20]];
		imm_i = {{20{ins[31]}}, ins[31:20]};
		imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
		imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
		imm_u = {ins[31:12], 12'b0};
		wr    = 1'b0;
		res   = '0;
		taken = 1'b0;
		npc   = model_pc + 32'd4;
		case (ins[6:0])
			OP_REG: begin
				wr  = (f7 == F7_BASE) || (f7 == F7_ALT && (f3 == F3_ADD_SUB || f3 == F3_SR));
				res = alu_ref(f3, f7[5], a, b);
			end
			OP_IMM: begin
				if (f3 == F3_SLL)
					wr = (f7 == F7_BASE);
				else if (f3 == F3_SR)
					wr = (f7 == F7_BASE) || (f7 == F7_ALT);
				else
					wr = 1'b1;
				res = alu_ref(f3, f3 == F3_SR && f7[5], a, imm_i);
			end
			OP_LUI: begin
				wr  = 1'b1;
				res = imm_u;
			end
			OP_AUIPC: begin
				wr  = 1'b1;
				res = model_pc + imm_u;
			end
			OP_JAL: begin
				wr  = 1'b1;
				res = model_pc + 32'd4;
				npc = model_pc + imm_j;
			end
			OP_BRANCH: begin
				case (f3)
					F3_BEQ:  taken = (a == b);
					F3_BNE:  taken = (a != b);
					F3_BLT:  taken = ($signed(a) < $signed(b));
					F3_BGE:  taken = ($signed(a) >= $signed(b));
					F3_BLTU: taken = (a < b);
					F3_BGEU: taken = (a >= b);
					default: taken = 1'b0; // undefined condition
				endcase
				if (taken)
					npc = model_pc + imm_b;
			end
			default: ;
		endcase
		ret.pc    = model_pc;
		ret.rd    = ins[11:7];
		ret.wen   = wr && (ins[11:7] != 5'd0);
		ret.wdata = res;
		if (ret.wen)
			model_regs[ins[11:7]] = res;
		model_pc = npc;
		return ret;
	endfunction

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic compare_value(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		if (exp !== act)
			stop_with_failure($sformatf("Error: %s expected %h actual %h", name, exp, act));
	endtask

	task automatic end_run();
		$display("TESTBENCH PASSED");
		$finish;
	endtask

	initial begin
		for (int i = 0; i < PROG_WORDS; i++)
			prog[i] = gen_instr();
		for (int i = 0; i < NUM_REGS; i++)
			model_regs[i] = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

	// instruction memory with 0..3 cycle delays on both channels
	always @(posedge clk) begin
		if (!rst) begin
			if (!ar_valid) begin
				ar_cnt = 2'(rand_bits(2));
			end else if (ar_ready) begin
				ar_ready <= 1'b0;
				rd_addr  = ar.araddr;
				r_cnt    = 2'(rand_bits(2));
				r_pend   = 1'b1;
			end else if (ar_cnt == 2'd0) begin
				ar_ready <= 1'b1;
			end else begin
				ar_cnt--;
			end
			if (r_valid && r_ready) begin
				r_valid <= 1'b0;
			end else if (r_pend) begin
				if (r_cnt == 2'd0) begin
					r_valid <= 1'b1;
					r       <= '{rdata: prog[rd_addr[9:2]], rresp: 2'b00};
					r_pend  = 1'b0;
				end else begin
					r_cnt--;
				end
			end
		end
	end

	always @(posedge clk) begin
		retire_t exp_ret;
		if (!rst) begin
			cycles++;
			if (cycles >= TIMEOUT)
				stop_with_failure("timeout: the core stopped retiring instructions");
			if (i_core_top.i_core_ctrl.i_core_props.fail_count != 0)
				stop_with_failure("a bus or trace property failed");
			if (ar_valid && ar_ready) begin
				// the model pc already points at the next instruction, 0 after reset
				compare_value($sformatf("fetch %0d address", retired), model_pc, ar.araddr);
				compare_value($sformatf("fetch %0d arprot", retired),
					32'd0, 32'(ar.arprot));
			end
			if (r_valid && r_ready)
				r_seen = 1'b1;
			if (retire_valid) begin
				if (!r_seen)
					stop_with_failure("an instruction retired before any read data arrived");
				exp_ret = ref_step();
				compare_value($sformatf("retire %0d pc", retired), exp_ret.pc, retire.pc);
				compare_value($sformatf("retire %0d wen", retired),
					32'(exp_ret.wen), 32'(retire.wen));
				if (exp_ret.wen) begin
					compare_value($sformatf("retire %0d rd", retired),
						32'(exp_ret.rd), 32'(retire.rd));
					compare_value($sformatf("retire %0d wdata", retired),
						exp_ret.wdata, retire.wdata);
				end
				retired++;
				if (retired == NUM_RETIRES)
					end_run();
			end
		end
	end

endmodule
